/* src/icache_pkg.sv */
`default_nettype none

package icache_pkg;

	// one instruction word, also used for byte addresses
	typedef logic [31:0] word_t;

	// tag field wide enough for the smallest index and offset
	localparam int MAX_TAG_BITS = 30;

	// valid bit sits above the tag, so an all-zero record is invalid
	typedef struct packed {
		logic                    valid;
		logic [MAX_TAG_BITS-1:0] tag;   // zero-extended when the real tag is shorter
	} tag_rec_t;

	// default geometry
	localparam int DEF_WAYS        = 2;
	localparam int DEF_SET_BITS    = 4;  // 16 sets
	localparam int DEF_OFFSET_BITS = 2;  // four words per line

endpackage

`default_nettype wire

/* src/icache_fill_if.sv */
`default_nettype none

// one finished line travelling from the refill FSM to the ways
interface icache_fill_if import icache_pkg::*; #(
	parameter int WAYS        = DEF_WAYS,
	parameter int SET_BITS    = DEF_SET_BITS,
	parameter int OFFSET_BITS = DEF_OFFSET_BITS
);
	localparam int WAY_BITS   = (WAYS > 1) ? $clog2(WAYS) : 1;
	localparam int TAG_BITS   = 32 - SET_BITS - OFFSET_BITS - 2;
	localparam int LINE_WORDS = 1 << OFFSET_BITS;

	logic                        fill_we;     // single-cycle write pulse
	logic [WAY_BITS-1:0]         fill_way;    // victim way
	logic [SET_BITS-1:0]         fill_index;  // set being written
	logic [TAG_BITS-1:0]         fill_tag;
	word_t [LINE_WORDS-1:0]      fill_line;   // word 0 in the low slot

	modport source (output fill_we, fill_way, fill_index, fill_tag, fill_line);
	modport sink   (input  fill_we, fill_way, fill_index, fill_tag, fill_line);

endinterface

`default_nettype wire

/* src/icache_way_ram.sv */
`default_nettype none

module icache_way_ram import icache_pkg::*; #(
	parameter int  SET_BITS  = DEF_SET_BITS,
	parameter type payload_t = tag_rec_t
) (
	input  logic                clk,
	input  logic                reset,
	input  logic [SET_BITS-1:0] rd_index,
	output payload_t            rd_data,
	input  logic                we,
	input  logic [SET_BITS-1:0] wr_index,
	input  payload_t            wr_data
);
	localparam int SETS = 1 << SET_BITS;

	payload_t mem [SETS];  // one entry per set

	assign rd_data = mem[rd_index];  // async read, lookup is combinational

	// zeroing marks every tag record invalid
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int s = 0; s < SETS; s++)
				mem[s] <= '0;
		end
		else if (we)
		begin
			mem[wr_index] <= wr_data;  // new contents seen the cycle after the pulse
		end
	end

endmodule

`default_nettype wire

/* src/icache_lookup.sv */
`default_nettype none

module icache_lookup import icache_pkg::*; #(
	parameter int   WAYS        = DEF_WAYS,
	parameter int   SET_BITS    = DEF_SET_BITS,
	parameter int   OFFSET_BITS = DEF_OFFSET_BITS,
	localparam int  WAY_BITS    = (WAYS > 1) ? $clog2(WAYS) : 1,
	localparam int  LINE_WORDS  = 1 << OFFSET_BITS
) (
	input  logic                   clk,
	input  logic                   reset,
	input  word_t                  instr_addr,
	icache_fill_if.sink            fill,
	output logic                   hit,
	output logic [WAY_BITS-1:0]    hit_way,
	output word_t [LINE_WORDS-1:0] line_words  // whole line of the hit way
);
	localparam int TAG_BITS = 32 - SET_BITS - OFFSET_BITS - 2;

	typedef word_t [LINE_WORDS-1:0] line_t;

	logic [TAG_BITS-1:0] addr_tag;
	logic [SET_BITS-1:0] addr_index;
	tag_rec_t            way_rec [WAYS];   // tag record read from each way
	line_t               way_line [WAYS];  // line read from each way
	logic [WAYS-1:0]     way_match;
	tag_rec_t            new_rec;

	// tag | index | word offset | byte offset
	assign addr_tag   = instr_addr[31 -: TAG_BITS];
	assign addr_index = instr_addr[OFFSET_BITS + 2 +: SET_BITS];

	// filled lines are always valid
	assign new_rec = '{valid: 1'b1, tag: MAX_TAG_BITS'(fill.fill_tag)};

	for (genvar w = 0; w < WAYS; w++)
	begin : g_way
		logic way_we;

		assign way_we = fill.fill_we && (fill.fill_way == WAY_BITS'(w));  // only the victim writes

		icache_way_ram #(
			.SET_BITS  (SET_BITS),
			.payload_t (tag_rec_t)
		) u_tag_ram (
			.clk      (clk),
			.reset    (reset),
			.rd_index (addr_index),
			.rd_data  (way_rec[w]),
			.we       (way_we),
			.wr_index (fill.fill_index),
			.wr_data  (new_rec)
		);

		icache_way_ram #(
			.SET_BITS  (SET_BITS),
			.payload_t (line_t)
		) u_line_ram (
			.clk      (clk),
			.reset    (reset),
			.rd_index (addr_index),
			.rd_data  (way_line[w]),
			.we       (way_we),
			.wr_index (fill.fill_index),
			.wr_data  (fill.fill_line)
		);

		assign way_match[w] = way_rec[w].valid && (way_rec[w].tag == MAX_TAG_BITS'(addr_tag));
	end

	// at most one way matches, so or-ing the indices encodes it
	always_comb
	begin
		hit_way = '0;
		for (int w = 0; w < WAYS; w++)
			if (way_match[w])
				hit_way |= WAY_BITS'(w);
	end

	assign hit        = |way_match;
	assign line_words = way_line[hit_way];  // don't care on a miss

endmodule

`default_nettype wire

/* src/icache_replacement.sv */
`default_nettype none

module icache_replacement import icache_pkg::*; #(
	parameter int  WAYS     = DEF_WAYS,
	parameter int  SET_BITS = DEF_SET_BITS,
	localparam int WAY_BITS = (WAYS > 1) ? $clog2(WAYS) : 1
) (
	input  logic                clk,
	input  logic                reset,
	icache_fill_if.sink         fill,
	input  logic [SET_BITS-1:0] rd_index,  // set of the current request
	output logic [WAY_BITS-1:0] victim
);
	localparam int SETS = 1 << SET_BITS;

	logic [WAY_BITS-1:0] rr_ptr [SETS];  // next way to replace, per set

	assign victim = rr_ptr[rd_index];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int s = 0; s < SETS; s++)
				rr_ptr[s] <= '0;
		end
		else if (fill.fill_we)
		begin
			// wrap at WAYS, not at the counter width
			if (rr_ptr[fill.fill_index] == WAY_BITS'(WAYS - 1))
				rr_ptr[fill.fill_index] <= '0;
			else
				rr_ptr[fill.fill_index] <= rr_ptr[fill.fill_index] + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* src/icache_refill.sv */
`default_nettype none

module icache_refill import icache_pkg::*; #(
	parameter int  WAYS        = DEF_WAYS,
	parameter int  SET_BITS    = DEF_SET_BITS,
	parameter int  OFFSET_BITS = DEF_OFFSET_BITS,
	localparam int WAY_BITS    = (WAYS > 1) ? $clog2(WAYS) : 1
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                cpu_req,
	input  word_t               instr_addr,
	input  logic                hit,
	input  logic [WAY_BITS-1:0] victim,
	icache_fill_if.source       fill,
	output logic                mem_req,
	output word_t               mem_read_addr,
	input  logic                mem_addr_ok,
	input  logic                mem_data_ok,
	input  word_t               mem_read_data
);
	localparam int TAG_BITS   = 32 - SET_BITS - OFFSET_BITS - 2;
	localparam int LINE_WORDS = 1 << OFFSET_BITS;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQUEST,  // mem_req held until mem_addr_ok
		ST_WAIT,     // waiting on mem_data_ok
		ST_FILL      // one-cycle write into the victim way
	} state_t;

	state_t                 state;
	logic [OFFSET_BITS-1:0] word_cnt;  // word being fetched
	logic [TAG_BITS-1:0]    tag_q;
	logic [SET_BITS-1:0]    index_q;
	logic [WAY_BITS-1:0]    victim_q;
	word_t [LINE_WORDS-1:0] line_q;    // words collected so far
	logic                   miss_start;
	logic                   last_word;

	assign miss_start = (state == ST_IDLE) && cpu_req && !hit;
	assign last_word  = (word_cnt == OFFSET_BITS'(LINE_WORDS - 1));

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state    <= ST_IDLE;
			word_cnt <= '0;
		end
		else
		begin
			case (state)
				ST_IDLE:
					if (miss_start)
					begin
						state    <= ST_REQUEST;
						word_cnt <= '0;  // always start at word 0
					end
				ST_REQUEST:
					if (mem_addr_ok)
						state <= ST_WAIT;
				ST_WAIT:
					if (mem_data_ok)
					begin
						if (last_word)
						begin
							state <= ST_FILL;
						end
						else
						begin
							state    <= ST_REQUEST;
							word_cnt <= word_cnt + 1'b1;
						end
					end
				ST_FILL:
					state <= ST_IDLE;  // request hits on the next cycle
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// miss context is frozen so the cpu address may move meanwhile
	always_ff @(posedge clk)
	begin
		if (miss_start)
		begin
			tag_q    <= instr_addr[31 -: TAG_BITS];
			index_q  <= instr_addr[OFFSET_BITS + 2 +: SET_BITS];
			victim_q <= victim;
		end
		if (state == ST_WAIT && mem_data_ok)
			line_q[word_cnt] <= mem_read_data;
	end

	assign mem_req       = (state == ST_REQUEST);
	assign mem_read_addr = {tag_q, index_q, word_cnt, 2'b00};  // stable while mem_req waits

	assign fill.fill_we    = (state == ST_FILL);
	assign fill.fill_way   = victim_q;
	assign fill.fill_index = index_q;
	assign fill.fill_tag   = tag_q;
	assign fill.fill_line  = line_q;

endmodule

`default_nettype wire

/* src/icache_response.sv */
`default_nettype none

module icache_response import icache_pkg::*; #(
	parameter int  OFFSET_BITS = DEF_OFFSET_BITS,
	localparam int LINE_WORDS  = 1 << OFFSET_BITS
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   cpu_req,
	input  logic                   hit,
	input  logic [OFFSET_BITS-1:0] offset,      // word within the line
	input  word_t [LINE_WORDS-1:0] line_words,
	output logic                   cpu_addr_ok,
	output word_t                  instr_rdata,
	output logic                   cpu_data_ok
);
	word_t hit_word;

	assign hit_word    = line_words[offset];
	assign cpu_addr_ok = cpu_req && hit;  // a hit is accepted in the request cycle

	always_ff @(posedge clk)
	begin
		if (reset)
			cpu_data_ok <= 1'b0;
		else
			cpu_data_ok <= cpu_addr_ok;  // one-cycle pulse after acceptance
	end

	// data only captured on an accepted hit
	always_ff @(posedge clk)
	begin
		if (cpu_addr_ok)
			instr_rdata <= hit_word;
	end

endmodule

`default_nettype wire

/* src/icache.sv */
`default_nettype none

module icache import icache_pkg::*; #(
	parameter int  WAYS        = DEF_WAYS,
	parameter int  SET_BITS    = DEF_SET_BITS,
	parameter int  OFFSET_BITS = DEF_OFFSET_BITS,
	localparam int WAY_BITS    = (WAYS > 1) ? $clog2(WAYS) : 1,
	localparam int LINE_WORDS  = 1 << OFFSET_BITS
) (
	input  logic  clk,
	input  logic  reset,
	input  word_t instr_addr,
	input  logic  cpu_req,
	output logic  cpu_addr_ok,
	output logic  cpu_data_ok,
	output word_t instr_rdata,
	output logic  mem_req,
	output word_t mem_read_addr,
	input  word_t mem_read_data,
	input  logic  mem_addr_ok,
	input  logic  mem_data_ok
);
	logic                   hit;
	logic [WAY_BITS-1:0]    victim;
	word_t [LINE_WORDS-1:0] line_words;  // hit line
	logic [SET_BITS-1:0]    req_index;
	logic [OFFSET_BITS-1:0] req_offset;

	assign req_index  = instr_addr[OFFSET_BITS + 2 +: SET_BITS];
	assign req_offset = instr_addr[OFFSET_BITS + 1 : 2];

	icache_fill_if #(.WAYS(WAYS), .SET_BITS(SET_BITS), .OFFSET_BITS(OFFSET_BITS)) fill_bus ();

	icache_lookup #(.WAYS(WAYS), .SET_BITS(SET_BITS), .OFFSET_BITS(OFFSET_BITS)) u_lookup (
		.clk        (clk),
		.reset      (reset),
		.instr_addr (instr_addr),
		.fill       (fill_bus.sink),
		.hit        (hit),
		.hit_way    (),  // way already folded into line_words
		.line_words (line_words)
	);

	icache_replacement #(.WAYS(WAYS), .SET_BITS(SET_BITS)) u_replacement (
		.clk      (clk),
		.reset    (reset),
		.fill     (fill_bus.sink),
		.rd_index (req_index),
		.victim   (victim)
	);

	icache_refill #(.WAYS(WAYS), .SET_BITS(SET_BITS), .OFFSET_BITS(OFFSET_BITS)) u_refill (
		.clk           (clk),
		.reset         (reset),
		.cpu_req       (cpu_req),
		.instr_addr    (instr_addr),
		.hit           (hit),
		.victim        (victim),
		.fill          (fill_bus.source),
		.mem_req       (mem_req),
		.mem_read_addr (mem_read_addr),
		.mem_addr_ok   (mem_addr_ok),
		.mem_data_ok   (mem_data_ok),
		.mem_read_data (mem_read_data)
	);

	icache_response #(.OFFSET_BITS(OFFSET_BITS)) u_response (
		.clk         (clk),
		.reset       (reset),
		.cpu_req     (cpu_req),
		.hit         (hit),
		.offset      (req_offset),
		.line_words  (line_words),
		.cpu_addr_ok (cpu_addr_ok),
		.instr_rdata (instr_rdata),
		.cpu_data_ok (cpu_data_ok)
	);

endmodule

`default_nettype wire

/* bench/tb_fetch_mem.sv */
`default_nettype none

// read-only memory on the refill port, slowed by random acknowledge delays
module tb_fetch_mem import icache_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  mem_req,
	input  word_t mem_read_addr,
	output logic  mem_addr_ok,
	output logic  mem_data_ok,
	output word_t mem_read_data
);
	integer seed = 32'h7be9_ec3c;
	int     delay;
	word_t  fetch_addr;  // address taken with mem_addr_ok

	// each word is its word address xor a fixed pattern
	function automatic word_t word_at(input word_t addr);
		return {2'b00, addr[31:2]} ^ 32'h5a5a_0000;
	endfunction

	initial
	begin
		mem_addr_ok   = 1'b0;
		mem_data_ok   = 1'b0;
		mem_read_data = '0;
		forever
		begin
			@(posedge clk);
			#1;
			mem_addr_ok = 1'b0;  // both strobes last one cycle
			mem_data_ok = 1'b0;
			if (!reset && mem_req)
			begin
				delay = $random(seed) & 3;  // 0 to 3 cycles before the address is taken
				repeat (delay)
				begin
					@(posedge clk);
					#1;
				end
				mem_addr_ok = 1'b1;
				fetch_addr  = mem_read_addr;
				@(posedge clk);
				#1;
				mem_addr_ok = 1'b0;
				delay = $random(seed) & 3;  // and 0 to 3 more before the data
				repeat (delay)
				begin
					@(posedge clk);
					#1;
				end
				mem_data_ok   = 1'b1;
				mem_read_data = word_at(fetch_addr);
			end
		end
	end

endmodule

`default_nettype wire

/* bench/icache_tb.sv */
`default_nettype none

module icache_tb import icache_pkg::*; ();
	localparam int WAYS        = DEF_WAYS;
	localparam int SET_BITS    = DEF_SET_BITS;
	localparam int OFFSET_BITS = DEF_OFFSET_BITS;
	localparam int SETS        = 1 << SET_BITS;
	localparam int LINE_WORDS  = 1 << OFFSET_BITS;

	logic  clk   = 1'b0;
	logic  reset = 1'b1;  // set before any process runs
	logic  cpu_req;
	word_t instr_addr;
	logic  cpu_addr_ok;
	logic  cpu_data_ok;
	word_t instr_rdata;
	logic  mem_req;
	word_t mem_read_addr;
	word_t mem_read_data;
	logic  mem_addr_ok;
	logic  mem_data_ok;

	// stimulus table, one access per entry
	string tbl_name [$];
	word_t tbl_addr [$];
	bit    tbl_fetch [$];  // a line fetch is expected

	// reference residency per set and way
	word_t model_tag [SETS][WAYS];
	bit    model_valid [SETS][WAYS];
	int    model_ptr [SETS];

	word_t fetch_q [$];        // addresses accepted on the memory port
	word_t held_addr;
	bit    req_waiting = 1'b0;
	int    value_errors = 0;
	int    port_errors = 0;
	int    cycle_count = 0;

	icache #(.WAYS(WAYS), .SET_BITS(SET_BITS), .OFFSET_BITS(OFFSET_BITS)) dut0 (
		.clk           (clk),
		.reset         (reset),
		.instr_addr    (instr_addr),
		.cpu_req       (cpu_req),
		.cpu_addr_ok   (cpu_addr_ok),
		.cpu_data_ok   (cpu_data_ok),
		.instr_rdata   (instr_rdata),
		.mem_req       (mem_req),
		.mem_read_addr (mem_read_addr),
		.mem_read_data (mem_read_data),
		.mem_addr_ok   (mem_addr_ok),
		.mem_data_ok   (mem_data_ok)
	);

	tb_fetch_mem u_mem (
		.clk           (clk),
		.reset         (reset),
		.mem_req       (mem_req),
		.mem_read_addr (mem_read_addr),
		.mem_addr_ok   (mem_addr_ok),
		.mem_data_ok   (mem_data_ok),
		.mem_read_data (mem_read_data)
	);

	initial
	begin
		forever #2 clk = ~clk;
	end

	task automatic add_entry(input string name, input word_t addr, input bit fetch);
		tbl_name.push_back(name);
		tbl_addr.push_back(addr);
		tbl_fetch.push_back(fetch);
	endtask

	task automatic report_mismatch(input string test, input string what, input word_t exp,
		input word_t act);
		$display("CHECK FAILED %s: %s expected 0x%08h, actual 0x%08h", test, what, exp, act);
		value_errors++;
	endtask

	// round robin per set, pointer moves on every fill
	function automatic bit model_access_misses(input word_t addr);
		word_t line_tag;
		int    set_idx;
		line_tag = addr >> (OFFSET_BITS + 2 + SET_BITS);
		set_idx  = int'((addr >> (OFFSET_BITS + 2)) & word_t'(SETS - 1));
		for (int w = 0; w < WAYS; w++)
			if (model_valid[set_idx][w] && model_tag[set_idx][w] == line_tag)
				return 1'b0;
		model_valid[set_idx][model_ptr[set_idx]] = 1'b1;
		model_tag[set_idx][model_ptr[set_idx]]   = line_tag;
		model_ptr[set_idx] = (model_ptr[set_idx] + 1) % WAYS;
		return 1'b1;
	endfunction

	// memory port monitor, sampled mid-cycle where everything is settled
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (req_waiting)
				assert (mem_req && mem_read_addr == held_addr)
				else
				begin
					$display("mem_read_addr or mem_req changed before mem_addr_ok (was 0x%08h)",
						held_addr);
					port_errors++;
				end
			if (mem_req && mem_addr_ok)
				fetch_q.push_back(mem_read_addr);
			req_waiting = mem_req && !mem_addr_ok;
			held_addr   = mem_read_addr;
		end
	end

	task automatic run_entry(input int i);
		word_t addr;
		word_t line_base;
		word_t exp_data;
		int    wait_cycles;
		int    fetch_start;
		int    fetch_exp;
		bit    model_miss;
		addr       = tbl_addr[i];
		line_base  = addr & ~word_t'(LINE_WORDS * 4 - 1);
		exp_data   = {2'b00, addr[31:2]} ^ 32'h5a5a_0000;  // memory fill pattern
		fetch_exp  = tbl_fetch[i] ? LINE_WORDS : 0;
		model_miss = model_access_misses(addr);
		assert (model_miss == tbl_fetch[i])
		else report_mismatch(tbl_name[i], "table fetch flag", 32'(model_miss), 32'(tbl_fetch[i]));
		fetch_start = fetch_q.size();
		wait_cycles = 0;
		instr_addr  = addr;
		cpu_req     = 1'b1;
		@(negedge clk);
		while (!cpu_addr_ok)
		begin
			assert (!cpu_data_ok)
			else report_mismatch(tbl_name[i], "cpu_data_ok before accept", 32'd0, 32'd1);
			wait_cycles++;
			@(negedge clk);
		end
		if (!tbl_fetch[i])
			assert (wait_cycles == 0)  // a hit is taken in its own cycle
			else report_mismatch(tbl_name[i], "hit accept delay", 32'd0, 32'(wait_cycles));
		assert (fetch_q.size() - fetch_start == fetch_exp)
		else report_mismatch(tbl_name[i], "memory fetches", 32'(fetch_exp),
			32'(fetch_q.size() - fetch_start));
		if (fetch_q.size() - fetch_start == fetch_exp)
			for (int k = 0; k < fetch_exp; k++)
				assert (fetch_q[fetch_start + k] == line_base + word_t'(4 * k))
				else report_mismatch(tbl_name[i], "fetch address", line_base + word_t'(4 * k),
					fetch_q[fetch_start + k]);
		@(posedge clk);
		#1;
		cpu_req = 1'b0;
		@(negedge clk);
		assert (cpu_data_ok)  // exactly one cycle after acceptance
		else report_mismatch(tbl_name[i], "cpu_data_ok", 32'd1, 32'd0);
		assert (instr_rdata == exp_data)
		else report_mismatch(tbl_name[i], "instr_rdata", exp_data, instr_rdata);
		@(posedge clk);
		#1;
	endtask

	initial
	begin
		cpu_req    = 1'b0;
		instr_addr = '0;
		add_entry("cold_miss",         32'h0000_1008, 1'b1);
		add_entry("hit_word0",         32'h0000_1000, 1'b0);
		add_entry("hit_word1",         32'h0000_1004, 1'b0);
		add_entry("hit_word3",         32'h0000_100c, 1'b0);
		add_entry("second_line_miss",  32'h0000_2004, 1'b1);  // same set 0, other tag
		add_entry("alternate_a",       32'h0000_1000, 1'b0);
		add_entry("alternate_b",       32'h0000_2008, 1'b0);
		add_entry("alternate_a_again", 32'h0000_100c, 1'b0);
		add_entry("alternate_b_again", 32'h0000_200c, 1'b0);
		add_entry("other_set_miss",    32'h0000_1010, 1'b1);
		add_entry("third_line_evicts", 32'h0000_3000, 1'b1);  // pointer back at way 0
		add_entry("survivor_hit",      32'h0000_2000, 1'b0);
		add_entry("evicted_line_miss", 32'h0000_1004, 1'b1);
		add_entry("new_line_hit",      32'h0000_300c, 1'b0);
		add_entry("other_set_hit",     32'h0000_1014, 1'b0);
		add_entry("far_set_miss",      32'habcd_40f0, 1'b1);
		add_entry("far_set_hit",       32'habcd_40f8, 1'b0);
		for (int s = 0; s < SETS; s++)
		begin
			model_ptr[s] = 0;
			for (int w = 0; w < WAYS; w++)
				model_valid[s][w] = 1'b0;
		end
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		repeat (3)
		begin
			@(negedge clk);  // idle after reset, nothing may move
			assert (!cpu_data_ok && !mem_req)
			else report_mismatch("idle_after_reset", "{cpu_data_ok, mem_req}", 32'd0,
				32'({cpu_data_ok, mem_req}));
		end
		@(posedge clk);
		#1;
		for (int i = 0; i < tbl_addr.size(); i++)
			run_entry(i);
		$display("value errors: %0d, memory port errors: %0d", value_errors, port_errors);
		if (value_errors == 0 && port_errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// run limit from the table length, a full refill fits well inside 42 cycles
	initial
	begin
		int limit;
		wait (reset === 1'b0);
		limit = tbl_addr.size() * (4 * 8 + 10);
		while (cycle_count < limit)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: the cache never answered within %0d cycles", limit);
		$display("value errors: %0d, memory port errors: %0d", value_errors, port_errors);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

/* icache.f */
src/icache_pkg.sv
src/icache_fill_if.sv
src/icache_way_ram.sv
src/icache_lookup.sv
src/icache_replacement.sv
src/icache_refill.sv
src/icache_response.sv
src/icache.sv
bench/tb_fetch_mem.sv
bench/icache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the icache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module icache_tb -f icache.f -o icache_sim

out=$(./obj_dir/icache_sim)
echo "$out"

# exit status follows the pass line
grep -q "^=== PASS ===$" <<< "$out"
